//--- include/tb_rom_table.svh
// ROM loader download table
`ifndef TB_ROM_TABLE_SVH
`define TB_ROM_TABLE_SVH

// Download rows: active, host index, byte address, data byte
// One program word per line, high byte first
localparam int PROG_ROW_N = 24;
localparam dl_row_t PROG_ROWS [PROG_ROW_N] = '{
	'{1'b1, 8'd0, 16'h0000, 8'h12}, '{1'b1, 8'd0, 16'h0001, 8'h34},
	'{1'b1, 8'd0, 16'h0002, 8'h56}, '{1'b1, 8'd0, 16'h0003, 8'h78},
	'{1'b1, 8'd0, 16'h0004, 8'h9a}, '{1'b1, 8'd0, 16'h0005, 8'hbc},
	'{1'b1, 8'd0, 16'h0006, 8'hde}, '{1'b1, 8'd0, 16'h0007, 8'hf0},
	'{1'b1, 8'd0, 16'h0008, 8'h0f}, '{1'b1, 8'd0, 16'h0009, 8'h1e},
	'{1'b1, 8'd0, 16'h000a, 8'h2d}, '{1'b1, 8'd0, 16'h000b, 8'h3c},
	'{1'b1, 8'd0, 16'h000c, 8'h4b}, '{1'b1, 8'd0, 16'h000d, 8'h5a},
	'{1'b1, 8'd0, 16'h000e, 8'h69}, '{1'b1, 8'd0, 16'h000f, 8'h78},
	'{1'b1, 8'd0, 16'h0800, 8'ha1}, '{1'b1, 8'd0, 16'h0801, 8'hb2},   // Bank 1 word 0
	'{1'b1, 8'd0, 16'h0802, 8'hc3}, '{1'b1, 8'd0, 16'h0803, 8'hd4},
	'{1'b1, 8'd0, 16'h0804, 8'he5}, '{1'b1, 8'd0, 16'h0805, 8'hf6},
	'{1'b1, 8'd0, 16'h0806, 8'h07}, '{1'b1, 8'd0, 16'h0807, 8'h18}
};

localparam int DROP_ROW_N = 16;
localparam dl_row_t DROP_ROWS [DROP_ROW_N] = '{
	'{1'b1, 8'd0, 16'h0030, 8'h00}, '{1'b1, 8'd0, 16'h0031, 8'h00},   // Known zeros first
	'{1'b1, 8'd0, 16'h1010, 8'h00}, '{1'b1, 8'd0, 16'h1020, 8'h00},
	'{1'b1, 8'd0, 16'h1810, 8'h00},
	'{1'b0, 8'd0, 16'h0030, 8'haa}, '{1'b0, 8'd0, 16'h0031, 8'h55},   // Host not downloading
	'{1'b1, 8'd3, 16'h0030, 8'h11}, '{1'b1, 8'd3, 16'h0031, 8'h22},   // Other file index
	'{1'b1, 8'd1, 16'h1020, 8'h77},
	'{1'b1, 8'd0, 16'h0c00, 8'h5a}, '{1'b1, 8'd0, 16'h0c01, 8'ha5},   // Filler gap
	'{1'b1, 8'd0, 16'h0ffe, 8'h69}, '{1'b1, 8'd0, 16'h0fff, 8'h96},
	'{1'b1, 8'd0, 16'h3010, 8'hc3}, '{1'b1, 8'd0, 16'h1c00, 8'h3c}    // Above char ROM
};

// Readback rows: region, address inside the region, expected word
localparam int PROG_CHK_N = 12;
localparam chk_row_t PROG_CHKS [PROG_CHK_N] = '{
	'{PROG, 11'd0, 16'h1234},    '{PROG, 11'd1, 16'h5678},    '{PROG, 11'd2, 16'h9abc},
	'{PROG, 11'd3, 16'hdef0},    '{PROG, 11'd4, 16'h0f1e},    '{PROG, 11'd5, 16'h2d3c},
	'{PROG, 11'd6, 16'h4b5a},    '{PROG, 11'd7, 16'h6978},    '{PROG, 11'd1024, 16'ha1b2},
	'{PROG, 11'd1025, 16'hc3d4}, '{PROG, 11'd1026, 16'he5f6}, '{PROG, 11'd1027, 16'h0718}
};

localparam int DROP_CHK_N = 8;
localparam chk_row_t DROP_CHKS [DROP_CHK_N] = '{
	'{PROG, 11'h018, 16'h0000},  '{AUDIO, 11'h010, 16'h0000}, '{AUDIO, 11'h020, 16'h0000},
	'{CHAR, 11'h010, 16'h0000},  '{PROG, 11'd1536, 16'h0000}, '{PROG, 11'd1600, 16'h0000},
	'{PROG, 11'd2047, 16'h0000}, '{CHAR, 11'd1024, 16'h0000}   // Gap and unmapped reads
};

`endif

//--- bench/tb_rom_loader.sv
// ROM loader testbench
`timescale 1ns/1ps

module tb_rom_loader
	import rom_loader_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int FIFO_DEPTH = 4;
	localparam int RAND_N     = 8;   // Random bytes per byte region
	localparam int BURST_N    = 8;   // Longer than FIFO_DEPTH + 1

	typedef struct packed {
		logic       active;
		logic [7:0] index;
		dl_addr_t   addr;
		dl_byte_t   data;
	} dl_row_t;

	typedef struct packed {
		rom_region_e region;
		rom_addr_t   addr;
		rom_word_t   value;
	} chk_row_t;

	`include "tb_rom_table.svh"

	localparam int TABLE_ROWS = PROG_ROW_N + DROP_ROW_N + PROG_CHK_N + DROP_CHK_N
		+ 4 * RAND_N + 2 * BURST_N;
	localparam longint TIMEOUT_NS = longint'(TABLE_ROWS * 20 + 2000) * CLK_PERIOD;

	logic       clk_sys;
	logic       reset;
	logic       dl_active;
	logic       dl_wr;
	logic [7:0] dl_index;
	dl_addr_t   dl_addr;
	dl_byte_t   dl_data;
	logic       dl_wait;
	logic       rd_en;
	rom_read_t  rd_req;
	rom_word_t  rd_data;
	logic       rd_valid;

	int          errors;
	int          errors_at_start;   // Error count when the current test began
	int          tests_run;
	int          tests_failed;
	logic [31:0] seed;
	logic        wait_seen;         // dl_wait observed during a write
	dl_byte_t    audio_bytes [RAND_N];
	dl_byte_t    char_bytes  [RAND_N];
	dl_byte_t    burst_bytes [BURST_N];

	rom_loader_top #(.FIFO_DEPTH(FIFO_DEPTH)) UUT (
		.clk_sys, .reset, .dl_active, .dl_wr, .dl_index, .dl_addr, .dl_data, .dl_wait,
		.rd_en, .rd_req, .rd_data, .rd_valid
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic dl_row_t game_row(input dl_addr_t a, input dl_byte_t d);
		dl_row_t r;
		r.active = 1'b1;
		r.index  = GAME_INDEX;
		r.addr   = a;
		r.data   = d;
		return r;
	endfunction

	// ##################################################
	// # Host and game side drivers
	// ##################################################
	task automatic write_byte(input dl_row_t row);
		@(negedge clk_sys);
		while (dl_wait) begin
			wait_seen = 1'b1;
			@(posedge clk_sys);
			rd_en <= 1'b0;   // Host stalled, game side lets go
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		dl_active <= row.active;
		dl_index  <= row.index;
		dl_addr   <= row.addr;
		dl_data   <= row.data;
		dl_wr     <= 1'b1;
		@(posedge clk_sys);
		dl_wr <= 1'b0;   // One cycle strobe
	endtask

	// FIFO drains once the host is no longer held
	task automatic settle();
		@(negedge clk_sys);
		while (dl_wait)
			@(negedge clk_sys);
		repeat (FIFO_DEPTH + 6) @(posedge clk_sys);
	endtask

	task automatic read_check(input rom_region_e region, input rom_addr_t addr,
		input rom_word_t exp);
		@(posedge clk_sys);
		rd_en  <= 1'b1;
		rd_req <= '{region, addr};
		@(negedge clk_sys);
		if (rd_valid !== 1'b0) begin
			$display("mismatch at %0t ns: rd_valid = %b, expected 0", $time, rd_valid);
			errors++;
		end
		@(posedge clk_sys);
		rd_en <= 1'b0;
		@(negedge clk_sys);   // One cycle after rd_en
		if (rd_valid !== 1'b1) begin
			$display("mismatch at %0t ns: rd_valid = %b, expected 1", $time, rd_valid);
			errors++;
		end
		if (rd_data !== exp) begin
			$display("mismatch at %0t ns: rd_data %s[%0h] = %h, expected %h",
				$time, region.name(), addr, rd_data, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %0d %-14s passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %-14s failed, %0d errors", tests_run, name,
				errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// ##################################################
	// # Test sequence
	// ##################################################
	initial begin
		int i;
		reset           = 1'b1;
		dl_active       = 1'b0;
		dl_wr           = 1'b0;
		dl_index        = '0;
		dl_addr         = '0;
		dl_data         = '0;
		rd_en           = 1'b0;
		rd_req          = '0;
		errors          = 0;
		errors_at_start = 0;
		tests_run       = 0;
		tests_failed    = 0;
		seed            = 32'h339d;
		wait_seen       = 1'b0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		// Idle outputs after reset, then gap reads for read timing
		@(negedge clk_sys);
		if (dl_wait !== 1'b0) begin
			$display("mismatch at %0t ns: dl_wait = %b, expected 0", $time, dl_wait);
			errors++;
		end
		if (rd_valid !== 1'b0) begin
			$display("mismatch at %0t ns: rd_valid = %b, expected 0", $time, rd_valid);
			errors++;
		end
		read_check(PROG, 11'd1536, 16'h0000);
		read_check(CHAR, 11'd1024, 16'h0000);
		finish_test("reset_timing");

		for (i = 0; i < PROG_ROW_N; i++)
			write_byte(PROG_ROWS[i]);
		settle();
		for (i = 0; i < PROG_CHK_N; i++)
			read_check(PROG_CHKS[i].region, PROG_CHKS[i].addr, PROG_CHKS[i].value);
		finish_test("program_words");

		for (i = 0; i < RAND_N; i++) begin
			seed           = lcg_next(seed);
			audio_bytes[i] = seed[23:16];
			seed           = lcg_next(seed);
			char_bytes[i]  = seed[23:16];
			write_byte(game_row(dl_addr_t'(AUDIO_BASE + 16'h0100 + i), audio_bytes[i]));
			write_byte(game_row(dl_addr_t'(CHAR_BASE + 16'h0100 + i), char_bytes[i]));
		end
		settle();
		for (i = 0; i < RAND_N; i++) begin
			read_check(AUDIO, rom_addr_t'(11'h100 + i), {8'h00, audio_bytes[i]});
			read_check(CHAR, rom_addr_t'(11'h100 + i), {8'h00, char_bytes[i]});
		end
		finish_test("byte_regions");

		for (i = 0; i < DROP_ROW_N; i++)
			write_byte(DROP_ROWS[i]);
		settle();
		for (i = 0; i < DROP_CHK_N; i++)
			read_check(DROP_CHKS[i].region, DROP_CHKS[i].addr, DROP_CHKS[i].value);
		finish_test("dropped_writes");

		// Burst against a held read port
		wait_seen = 1'b0;
		@(posedge clk_sys);
		rd_en  <= 1'b1;
		rd_req <= '{PROG, 11'd0};
		for (i = 0; i < BURST_N; i++) begin
			seed           = lcg_next(seed);
			burst_bytes[i] = seed[23:16];
			write_byte(game_row(dl_addr_t'(CHAR_BASE + 16'h0200 + i), burst_bytes[i]));
		end
		@(posedge clk_sys);
		rd_en <= 1'b0;
		if (!wait_seen) begin
			$display("dl_wait never rose while reads held the banks");
			errors++;
		end
		settle();
		for (i = 0; i < BURST_N; i++)
			read_check(CHAR, rom_addr_t'(11'h200 + i), {8'h00, burst_bytes[i]});
		finish_test("back_pressure");

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired at %0t ns, a download or readback stalled", $time);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ROM loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rom_loader --Mdir "$OBJ" -o tb_rom_loader -f src.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/tb_rom_loader" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^All tests passed$" "$LOG"; then
	exit 0
fi

echo "Pass message not found in $LOG"
exit 1

//--- src.f
+incdir+include
src/rom_loader_pkg.sv
src/download_decoder.sv
src/write_fifo.sv
src/rom_banks.sv
src/rom_loader_top.sv
bench/tb_rom_loader.sv

//--- src/download_decoder.sv
// Host download decoder
`timescale 1ns/1ps

module download_decoder
	import rom_loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       dl_active,   // Download in progress
	input  logic       dl_wr,       // Byte strobe
	input  logic [7:0] dl_index,    // File index from host
	input  dl_addr_t   dl_addr,
	input  dl_byte_t   dl_data,
	output logic       dl_wait,     // Back-pressure to host
	output rom_write_t wr_req,
	output logic       wr_valid,
	input  logic       wr_ready
);

	logic       game_wr;    // Write that belongs to the game ROM set
	dl_byte_t   acc_byte;   // Previous game byte, high half of a program word
	dl_addr_t   prog_off;
	dl_addr_t   audio_off;
	dl_addr_t   char_off;
	logic       in_prog;
	logic       in_fill;
	logic       in_audio;
	logic       in_char;
	rom_write_t next_req;   // Request built from the current byte
	logic       next_hit;   // Current byte completes a request
	logic       take;       // Pending slot free this cycle

	assign game_wr = dl_wr && dl_active && (dl_index == GAME_INDEX);

	// ##################################################
	// # Region decode
	// ##################################################
	always_comb begin
		prog_off  = dl_addr - PROG0_BASE;
		audio_off = dl_addr - AUDIO_BASE;
		char_off  = dl_addr - CHAR_BASE;
		in_prog   = dl_addr <= PROG1_END;                           // Both program banks
		in_fill   = (dl_addr >= FILL_BASE) && (dl_addr <= FILL_END);
		in_audio  = (dl_addr >= AUDIO_BASE) && (dl_addr <= AUDIO_END);
		in_char   = (dl_addr >= CHAR_BASE) && (dl_addr <= CHAR_END);

		next_req  = '0;
		next_hit  = 1'b0;
		if (in_prog) begin
			// Word address, high byte arrived first
			next_req.region = PROG;
			next_req.addr   = prog_off[ROM_AW:1];
			next_req.data   = {acc_byte, dl_data};
			next_hit        = dl_addr[0];   // Write on the odd byte only
		end else if (in_fill) begin
			next_hit = 1'b0;                // Gap between program and audio
		end else if (in_audio) begin
			next_req.region = AUDIO;
			next_req.addr   = audio_off[ROM_AW-1:0];
			next_req.data   = {8'h00, dl_data};
			next_hit        = 1'b1;
		end else if (in_char) begin
			next_req.region = CHAR;
			next_req.addr   = char_off[ROM_AW-1:0];
			next_req.data   = {8'h00, dl_data};
			next_hit        = 1'b1;
		end
		// Unmapped space falls through with no request
	end

	// Slot frees when empty or when the FIFO takes the held request
	assign take = !wr_valid || wr_ready;

	// ##################################################
	// # Pending request
	// ##################################################
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_valid <= 1'b0;
		end else if (take) begin
			wr_valid <= game_wr && next_hit;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (game_wr)
			acc_byte <= dl_data;    // Every game byte shifts in
		if (take && game_wr && next_hit)
			wr_req <= next_req;
	end

	// Stalled request holds the host off
	assign dl_wait = wr_valid && !wr_ready;

	// Host honours the wait, so no byte is dropped behind a stall
	a_no_wr_during_wait: assert property (@(posedge clk_sys) disable iff (reset)
		!(dl_wr && dl_wait));

endmodule

//--- src/rom_banks.sv
// Game ROM banks with read port
`timescale 1ns/1ps

module rom_banks
	import rom_loader_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  rom_write_t wr_req,
	input  logic       wr_valid,
	output logic       wr_ready,
	input  logic       rd_en,      // Game side read strobe
	input  rom_read_t  rd_req,
	output rom_word_t  rd_data,    // Valid one cycle after rd_en
	output logic       rd_valid
);

	localparam int P0_AW = $clog2(PROG0_WORDS);
	localparam int P1_AW = $clog2(PROG1_WORDS);
	localparam int AU_AW = $clog2(AUDIO_BYTES);
	localparam int CH_AW = $clog2(CHAR_BYTES);

	// Program word decode
	localparam logic [1:0] SEL_P0  = 2'd0;
	localparam logic [1:0] SEL_P1  = 2'd1;
	localparam logic [1:0] SEL_GAP = 2'd2;   // Filler and above, reads zero

	rom_word_t  prog0 [PROG0_WORDS];
	rom_word_t  prog1 [PROG1_WORDS];
	dl_byte_t   audio [AUDIO_BYTES];
	dl_byte_t   chr   [CHAR_BYTES];

	logic       wr_fire;   // Write actually lands this cycle
	logic [1:0] wr_sel;
	logic [1:0] rd_sel;
	rom_addr_t  wr_p1;     // Offsets into bank 1
	rom_addr_t  rd_p1;

	function automatic logic [1:0] prog_sel(input rom_addr_t a);
		if (a < rom_addr_t'(PROG0_WORDS))
			return SEL_P0;
		else if (a < rom_addr_t'(PROG_WORDS))
			return SEL_P1;
		else
			return SEL_GAP;
	endfunction

	// Single port per bank, reads win
	assign wr_ready = !rd_en;
	assign wr_fire  = wr_valid && wr_ready;

	always_comb begin
		wr_sel = prog_sel(wr_req.addr);
		rd_sel = prog_sel(rd_req.addr);
		wr_p1  = wr_req.addr - rom_addr_t'(PROG0_WORDS);
		rd_p1  = rd_req.addr - rom_addr_t'(PROG0_WORDS);
	end

	// ##################################################
	// # Array port, write or registered read
	// ##################################################
	always_ff @(posedge clk_sys) begin
		if (wr_fire) begin
			case (wr_req.region)
				PROG: begin
					if (wr_sel == SEL_P0)
						prog0[wr_req.addr[P0_AW-1:0]] <= wr_req.data;
					else if (wr_sel == SEL_P1)
						prog1[wr_p1[P1_AW-1:0]] <= wr_req.data;
				end
				AUDIO: audio[wr_req.addr[AU_AW-1:0]] <= wr_req.data[7:0];
				CHAR: begin
					if (wr_req.addr < rom_addr_t'(CHAR_BYTES))
						chr[wr_req.addr[CH_AW-1:0]] <= wr_req.data[7:0];
				end
				default: ;   // Unused region code
			endcase
		end
		if (rd_en) begin
			rd_data <= '0;   // Gap and unmapped space
			case (rd_req.region)
				PROG: begin
					if (rd_sel == SEL_P0)
						rd_data <= prog0[rd_req.addr[P0_AW-1:0]];
					else if (rd_sel == SEL_P1)
						rd_data <= prog1[rd_p1[P1_AW-1:0]];
				end
				AUDIO: rd_data <= {8'h00, audio[rd_req.addr[AU_AW-1:0]]};
				CHAR: begin
					if (rd_req.addr < rom_addr_t'(CHAR_BYTES))
						rd_data <= {8'h00, chr[rd_req.addr[CH_AW-1:0]]};
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_en;   // Fixed one cycle read latency
	end

	// A write pushed back by a read stays offered, unchanged, by the FIFO
	a_write_held: assert property (@(posedge clk_sys) disable iff (reset)
		rd_en && wr_valid |=> wr_valid && $stable(wr_req));

endmodule

//--- src/rom_loader_pkg.sv
// ROM loader shared definitions

package rom_loader_pkg;

	// ##################################################
	// # Widths and basic types
	// ##################################################
	localparam int DL_AW  = 16;         // Host byte address
	localparam int DL_DW  = 8;          // Host data byte
	localparam int ROM_DW = 16;         // Widest ROM word
	localparam int ROM_AW = 11;         // Covers the 2 KB audio region

	typedef logic [DL_AW-1:0]  dl_addr_t;
	typedef logic [DL_DW-1:0]  dl_byte_t;
	typedef logic [ROM_DW-1:0] rom_word_t;  // Byte regions zero-extend into this
	typedef logic [ROM_AW-1:0] rom_addr_t;  // Word or byte offset inside a region

	// Host index carrying the game ROM set
	localparam logic [7:0] GAME_INDEX = 8'd0;

	// Default depth of the write request buffer
	localparam int FIFO_DEPTH_DEF = 4;

	// ##################################################
	// # Bank sizes
	// ##################################################
	localparam int PROG0_WORDS = 1024;
	localparam int PROG1_WORDS = 512;                        // Smaller second program bank
	localparam int PROG_WORDS  = PROG0_WORDS + PROG1_WORDS;  // First word of the gap
	localparam int AUDIO_BYTES = 2048;
	localparam int CHAR_BYTES  = 1024;

	// ##################################################
	// # Download address map, byte addresses
	// ##################################################
	localparam dl_addr_t PROG0_BASE = 16'h0000;
	localparam dl_addr_t PROG0_END  = dl_addr_t'(PROG0_BASE + 2 * PROG0_WORDS - 1);
	localparam dl_addr_t PROG1_BASE = dl_addr_t'(PROG0_END + 1);
	localparam dl_addr_t PROG1_END  = dl_addr_t'(PROG1_BASE + 2 * PROG1_WORDS - 1);
	localparam dl_addr_t FILL_BASE  = dl_addr_t'(PROG1_END + 1);   // Filler, no ROM behind it
	localparam dl_addr_t FILL_END   = 16'h0FFF;
	localparam dl_addr_t AUDIO_BASE = dl_addr_t'(FILL_END + 1);
	localparam dl_addr_t AUDIO_END  = dl_addr_t'(AUDIO_BASE + AUDIO_BYTES - 1);
	localparam dl_addr_t CHAR_BASE  = dl_addr_t'(AUDIO_END + 1);
	localparam dl_addr_t CHAR_END   = dl_addr_t'(CHAR_BASE + CHAR_BYTES - 1);
	// Anything above CHAR_END is ignored

	// ##################################################
	// # Regions and requests
	// ##################################################
	typedef enum logic [1:0] {
		PROG  = 2'd0,   // 16-bit program words, two banks
		AUDIO = 2'd1,   // Sound CPU bytes
		CHAR  = 2'd2    // Character tile bytes
	} rom_region_e;

	// Decoder to FIFO to banks, 29 bits
	typedef struct packed {
		rom_region_e region;
		rom_addr_t   addr;
		rom_word_t   data;
	} rom_write_t;

	// Game side read, 13 bits
	typedef struct packed {
		rom_region_e region;
		rom_addr_t   addr;
	} rom_read_t;

endpackage

//--- src/rom_loader_top.sv
// ROM download path top level
`timescale 1ns/1ps

module rom_loader_top
	import rom_loader_pkg::*;
#(
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
	input  logic       clk_sys,
	input  logic       reset,
	// Host download side
	input  logic       dl_active,
	input  logic       dl_wr,
	input  logic [7:0] dl_index,
	input  dl_addr_t   dl_addr,
	input  dl_byte_t   dl_data,
	output logic       dl_wait,
	// Game read side
	input  logic       rd_en,
	input  rom_read_t  rd_req,
	output rom_word_t  rd_data,
	output logic       rd_valid
);

	rom_write_t dec_req;     // Decoder to FIFO
	logic       dec_valid;
	logic       dec_ready;
	rom_write_t bank_req;    // FIFO to banks
	logic       bank_valid;
	logic       bank_ready;  // Low while the game side reads

	download_decoder u_decoder (
		.clk_sys, .reset, .dl_active, .dl_wr, .dl_index, .dl_addr, .dl_data, .dl_wait,
		.wr_req(dec_req), .wr_valid(dec_valid), .wr_ready(dec_ready)
	);

	write_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk_sys, .reset,
		.in_req(dec_req), .in_valid(dec_valid), .in_ready(dec_ready),
		.out_req(bank_req), .out_valid(bank_valid), .out_ready(bank_ready)
	);

	rom_banks u_banks (
		.clk_sys, .reset,
		.wr_req(bank_req), .wr_valid(bank_valid), .wr_ready(bank_ready),
		.rd_en, .rd_req, .rd_data, .rd_valid
	);

endmodule

//--- src/write_fifo.sv
// ROM write request FIFO
`timescale 1ns/1ps

module write_fifo
	import rom_loader_pkg::*;
#(
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEF   // Power of two, 2 or more
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  rom_write_t in_req,
	input  logic       in_valid,
	output logic       in_ready,
	output rom_write_t out_req,
	output logic       out_valid,
	input  logic       out_ready
);

	localparam int             PTR_W      = $clog2(FIFO_DEPTH);
	localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

	rom_write_t       mem [FIFO_DEPTH];  // Circular storage
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;             // Entries held, 0 to FIFO_DEPTH
	logic             push;
	logic             pop;

	assign in_ready  = count != FULL_COUNT;   // Low exactly while full
	assign out_valid = count != '0;
	assign out_req   = mem[rd_ptr];           // Head of queue
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	// ##################################################
	// # Pointers and fill level
	// ##################################################
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;   // Wraps naturally
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // Idle or push and pop together
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push)
			mem[wr_ptr] <= in_req;
	end

	// Refused request stays offered, unchanged, while the queue is full
	a_hold_when_full: assert property (@(posedge clk_sys) disable iff (reset)
		in_valid && !in_ready |=> in_valid && $stable(in_req));

	// Fill level never overflows or wraps below zero, and tracks the pointer distance
	a_level_matches_ptrs: assert property (@(posedge clk_sys) disable iff (reset)
		(count <= FULL_COUNT) && ((wr_ptr - rd_ptr) == count[PTR_W-1:0]));

endmodule
